//--- all.f
+incdir+include
hw/ddcPkg.sv
hw/gainRegs.sv
hw/cicDecimator.sv
hw/mpy18x18.sv
hw/variableGain.sv
hw/ddcChannel.sv
sim/ddcChannel_assertions.sv
sim/ddcChannel_tb.sv

//--- hw/cicDecimator.sv
`timescale 1ns/1ps
`include "ddc_consts.svh"

module cicDecimator (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        sampleEn,
    input  logic [`SAMPLE_WIDTH-1:0]    sampleIn,
    output logic [`ACC_WIDTH-1:0]       cicOut,
    output logic                        cicOutEn
);

    localparam int PhaseWidth = $clog2(`DECIM_RATE);
    localparam int ExtWidth   = `ACC_WIDTH - `SAMPLE_WIDTH;

    logic [PhaseWidth-1:0]  phase;
    logic                   decimStrobe;
    logic [`ACC_WIDTH-1:0]  sampleExt;
    logic [`ACC_WIDTH-1:0]  integ   [`CIC_ORDER];
    logic [`ACC_WIDTH-1:0]  combIn  [`CIC_ORDER];
    logic [`ACC_WIDTH-1:0]  combDly [`CIC_ORDER];
    logic [`ACC_WIDTH-1:0]  combResult;

    assign sampleExt   = {{ExtWidth{sampleIn[`SAMPLE_WIDTH-1]}}, sampleIn};
    assign decimStrobe = sampleEn && (phase == PhaseWidth'(`DECIM_RATE - 1));

    //////////////////////////////////////////////////////////////////////
    // Input rate side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (sampleEn) begin
            if (decimStrobe) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Integrators wrap at 48 bits; the combs undo the wrap.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CIC_ORDER; i++) begin
                integ[i] <= '0;
            end
        end else if (sampleEn) begin
            integ[0] <= integ[0] + sampleExt;
            for (int i = 1; i < `CIC_ORDER; i++) begin
                integ[i] <= integ[i] + integ[i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decimated side
    //////////////////////////////////////////////////////////////////////

    // Comb chain settles within the strobe cycle.
    always_comb begin
        logic [`ACC_WIDTH-1:0] acc;
        acc = integ[`CIC_ORDER-1];
        for (int i = 0; i < `CIC_ORDER; i++) begin
            combIn[i] = acc;
            acc = acc - combDly[i];
        end
        combResult = acc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CIC_ORDER; i++) begin
                combDly[i] <= '0;
            end
            cicOut   <= '0;
            cicOutEn <= 1'b0;
        end else begin
            cicOutEn <= decimStrobe;            // Pulse with the new result.
            if (decimStrobe) begin
                for (int i = 0; i < `CIC_ORDER; i++) begin
                    combDly[i] <= combIn[i];
                end
                cicOut <= combResult;           // Held until the next strobe.
            end
        end
    end

endmodule

//--- hw/ddcChannel.sv
`timescale 1ns/1ps
`include "ddc_consts.svh"

module ddcChannel import ddcPkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        sampleEn,
    input  logic [`SAMPLE_WIDTH-1:0]    sampleIn,
    input  regBusReq                    regReq,
    output logic [`REG_DATA_WIDTH-1:0]  regReadData,
    output logic [`OUT_WIDTH-1:0]       gainOut,
    output logic                        gainOutEn
);

    logic [`ACC_WIDTH-1:0]  cicOut;
    logic                   cicOutEn;
    gainSetting             activeGain;

    // Gain registers, applied on each decimated sample.
    gainRegs u_gainRegs (
        .clk         (clk),
        .reset       (reset),
        .regReq      (regReq),
        .apply       (cicOutEn),
        .regReadData (regReadData),
        .activeGain  (activeGain)
    );

    cicDecimator u_cicDecimator (
        .clk      (clk),
        .reset    (reset),
        .sampleEn (sampleEn),
        .sampleIn (sampleIn),
        .cicOut   (cicOut),
        .cicOutEn (cicOutEn)
    );

    // Runs at the decimated rate.
    variableGain u_variableGain (
        .clk    (clk),
        .clkEn  (cicOutEn),
        .reset  (reset),
        .gain   (activeGain),
        .din    (cicOut),
        .dout   (gainOut),
        .doutEn (gainOutEn)
    );

endmodule

//--- hw/ddcPkg.sv
`include "ddc_consts.svh"

package ddcPkg;

    //////////////////////////////////////////////////////////////////////
    // Gain setting
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`EXP_WIDTH-1:0]  exponent;   // Power of two shift.
        logic [`MANT_WIDTH-1:0] mantissa;   // Fraction in 1 + m/65536.
    } gainSetting;

    //////////////////////////////////////////////////////////////////////
    // Register bus
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [`REG_ADDR_WIDTH-1:0] {
        REG_GAIN_EXP  = `REG_ADDR_GAIN_EXP,
        REG_GAIN_MANT = `REG_ADDR_GAIN_MANT,
        REG_STATUS    = `REG_ADDR_STATUS    // Active exponent, read only.
    } regAddr;

    // One request per cycle, write and read are single-clock strobes.
    typedef struct packed {
        logic                       wrEn;
        logic                       rdEn;
        regAddr                     addr;
        logic [`REG_DATA_WIDTH-1:0] wrData;
    } regBusReq;

endpackage

//--- hw/gainRegs.sv
`timescale 1ns/1ps
`include "ddc_consts.svh"

module gainRegs import ddcPkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  regBusReq                    regReq,
    input  logic                        apply,
    output logic [`REG_DATA_WIDTH-1:0]  regReadData,
    output gainSetting                  activeGain
);

    localparam int ExpPad = `REG_DATA_WIDTH - `EXP_WIDTH;

    gainSetting shadowGain;

    // Bus writes go to the shadow copy.
    // The active copy only moves on a decimated-sample strobe.
    always_ff @(posedge clk) begin
        if (reset) begin
            shadowGain <= '0;
            activeGain <= '0;
        end else begin
            if (regReq.wrEn) begin
                case (regReq.addr)
                    REG_GAIN_EXP: begin
                        shadowGain.exponent <= regReq.wrData[`EXP_WIDTH-1:0];
                    end
                    REG_GAIN_MANT: begin
                        shadowGain.mantissa <= regReq.wrData[`MANT_WIDTH-1:0];
                    end
                    default: begin
                    end                                 // Status is read only.
                endcase
            end
            if (apply) begin
                activeGain <= shadowGain;               // Gain changes between samples.
            end
        end
    end

    // Readback, data valid the cycle after the strobe.
    always_ff @(posedge clk) begin
        if (regReq.rdEn) begin
            case (regReq.addr)
                REG_GAIN_EXP: begin
                    regReadData <= {{ExpPad{1'b0}}, shadowGain.exponent};
                end
                REG_GAIN_MANT: begin
                    regReadData <= shadowGain.mantissa;
                end
                REG_STATUS: begin
                    regReadData <= {{ExpPad{1'b0}}, activeGain.exponent};
                end
                default: begin
                    regReadData <= '0;
                end
            endcase
        end
    end

endmodule

//--- hw/mpy18x18.sv
`timescale 1ns/1ps

module mpy18x18 (
    input  logic                clk,
    input  logic signed [17:0]  a,
    input  logic signed [17:0]  b,
    output logic signed [35:0]  p
);

    logic signed [35:0] product;

    // Maps onto a single DSP multiplier with its output register.
    assign product = a * b;

    always_ff @(posedge clk) begin
        p <= product;                           // One clock of latency.
    end

endmodule

//--- hw/variableGain.sv
`timescale 1ns/1ps
`include "ddc_consts.svh"

module variableGain import ddcPkg::*; (
    input  logic                        clk,
    input  logic                        clkEn,
    input  logic                        reset,
    input  gainSetting                  gain,
    input  logic [`ACC_WIDTH-1:0]       din,
    output logic [`OUT_WIDTH-1:0]       dout,
    output logic                        doutEn
);

    localparam int ProdMsb  = 2 * `OUT_WIDTH - 1;
    localparam int ScalePad = `OUT_WIDTH - `MANT_WIDTH - 1;

    logic                           sign;
    logic [`ACC_WIDTH-1:0]          shiftedDin;
    logic signed [`ACC_WIDTH-1:0]   restoredDin;
    logic                           overflow;
    logic [`OUT_WIDTH-1:0]          dataBits;
    logic                           satPos;
    logic                           satNeg;
    logic [`MANT_WIDTH-1:0]         mant1;
    logic [`MANT_WIDTH-1:0]         mant2;
    logic signed [`OUT_WIDTH-1:0]   shift;
    logic signed [`OUT_WIDTH-1:0]   scale;
    logic signed [ProdMsb:0]        scaledValue;
    logic [2:0]                     prodTop;
    logic [1:0]                     enPipe;

    //////////////////////////////////////////////////////////////////////
    // Saturating shifter
    //////////////////////////////////////////////////////////////////////

    assign sign        = din[`ACC_WIDTH-1];
    assign shiftedDin  = din << gain.exponent;
    assign restoredDin = $signed(shiftedDin) >>> gain.exponent;
    assign overflow    = restoredDin != $signed(din);  // Lost bits differ from the sign.

    always_ff @(posedge clk) begin
        if (reset) begin
            dataBits <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
            mant1    <= '0;
            mant2    <= '0;
            shift    <= '0;
        end else if (clkEn) begin
            dataBits <= shiftedDin[`ACC_WIDTH-1 -: `OUT_WIDTH];
            satPos   <= overflow && !sign;
            satNeg   <= overflow && sign;
            mant1    <= gain.mantissa;          // Keep the mantissa paired with its exponent.
            mant2    <= mant1;
            if (satPos) begin
                shift <= `SAT_POS;
            end else if (satNeg) begin
                shift <= `SAT_NEG;
            end else begin
                shift <= dataBits;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Mantissa scaling and output saturation
    //////////////////////////////////////////////////////////////////////

    // Scale is 1 + m/65536 in Q2.16.
    assign scale = {{ScalePad{1'b0}}, 1'b1, mant2};

    mpy18x18 gainScaler (
        .clk (clk),
        .a   (shift),
        .b   (scale),
        .p   (scaledValue)
    );

    assign prodTop = scaledValue[ProdMsb -: 3];

    always_ff @(posedge clk) begin
        if (reset) begin
            enPipe <= '0;
            doutEn <= 1'b0;
            dout   <= '0;
        end else begin
            enPipe <= {enPipe[0], clkEn};
            doutEn <= enPipe[1];                // Lines up with the new dout.
            if (enPipe[1]) begin
                if (prodTop[2] && (prodTop != 3'b111)) begin
                    dout <= `SAT_NEG;
                end else if (!prodTop[2] && (prodTop != 3'b000)) begin
                    dout <= `SAT_POS;
                end else begin
                    dout <= scaledValue[ProdMsb-2 -: `OUT_WIDTH];  // Truncate.
                end
            end
        end
    end

endmodule

//--- include/ddc_consts.svh
`ifndef DDC_CONSTS_SVH
`define DDC_CONSTS_SVH

// Datapath widths.
`define SAMPLE_WIDTH        24
`define ACC_WIDTH           48
`define OUT_WIDTH           18

// CIC shape, DC gain is DECIM_RATE ** CIC_ORDER = 2^18.
`define DECIM_RATE          64
`define CIC_ORDER           3

// Gain fields.
`define MANT_WIDTH          16
`define EXP_WIDTH           4

// Symmetric 18 bit output range.
`define SAT_POS             18'h1FFFF
`define SAT_NEG             18'h20001

// Register bus.
`define REG_DATA_WIDTH      16
`define REG_ADDR_WIDTH      2
`define REG_ADDR_GAIN_EXP   2'd0
`define REG_ADDR_GAIN_MANT  2'd1
`define REG_ADDR_STATUS     2'd2

`endif

//--- run.sh
#!/bin/sh
# Builds the ddcChannel testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ddcChannel_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ddcChannel_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Assertion errors are counted by the testbench, so the run keeps going after one.
"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "Something failed" "$LOG_FILE"
status=$?
if [ $status -eq 0 ]; then
    echo "Test failed, see $LOG_FILE"
    exit 1
fi
if [ $status -ne 1 ]; then
    echo "Could not search $LOG_FILE"
    exit 1
fi

echo "Test passed"
exit 0

//--- sim/ddcChannel_assertions.sv
`timescale 1ns/1ps
`include "ddc_consts.svh"

module ddcChannel_assertions (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cicOutEn,
    input  logic                    gainOutEn,
    input  logic [`OUT_WIDTH-1:0]   gainOut
);

    int assertFails = 0;                    // Summed into the testbench result.

    // Output strobe is a single-clock pulse.
    gainOutEnPulse: assert property (@(posedge clk) disable iff (reset)
        gainOutEn |=> !gainOutEn)
    else begin
        $error("gainOutEn stayed high for two consecutive cycles");
        assertFails++;
    end

    resetClears: assert property (@(posedge clk)
        reset |=> (!cicOutEn && !gainOutEn && (gainOut == '0)))
    else begin
        $error("Reset did not clear the strobes and gainOut");
        assertFails++;
    end

    // The most negative code is outside the symmetric range.
    outputRange: assert property (@(posedge clk) disable iff (reset)
        $signed(gainOut) >= $signed(`SAT_NEG))
    else begin
        $error("gainOut holds the code 0x20000");
        assertFails++;
    end

endmodule

bind ddcChannel ddcChannel_assertions u_ddcChannel_assertions (
    .clk       (clk),
    .reset     (reset),
    .cicOutEn  (cicOutEn),
    .gainOutEn (gainOutEn),
    .gainOut   (gainOut)
);

//--- sim/ddcChannel_tb.sv
`timescale 1ns/1ps
`include "ddc_consts.svh"

module ddcChannel_tb import ddcPkg::*; ();

    localparam int ClkPeriod   = 100;
    localparam int DriveDelay  = 10;
    localparam int ResetCycles = 5;
    localparam int SampleStep  = 2;             // Clocks per input sample.
    localparam int RecWords    = 5;
    localparam int MaxRecords  = 32;

    logic                       clk;
    logic                       reset;
    logic                       sampleEn;
    logic [`SAMPLE_WIDTH-1:0]   sampleIn;
    regBusReq                   regReq;
    logic [`REG_DATA_WIDTH-1:0] regReadData;
    logic [`OUT_WIDTH-1:0]      gainOut;
    logic                       gainOutEn;

    logic [31:0]    stim [RecWords*MaxRecords];
    int             numRecords;
    int             totalStrobes;
    int             samplesSent;
    int             checks;
    int             errors;
    bit             loaded;
    bit             firstPulseSeen;

    ddcChannel u_ddcChannel (
        .clk         (clk),
        .reset       (reset),
        .sampleEn    (sampleEn),
        .sampleIn    (sampleIn),
        .regReq      (regReq),
        .regReadData (regReadData),
        .gainOut     (gainOut),
        .gainOutEn   (gainOutEn)
    );

    always #(ClkPeriod/2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic waitDriveSlot();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic writeReg(input regAddr addr, input logic [`REG_DATA_WIDTH-1:0] data);
        waitDriveSlot();
        regReq.wrEn   = 1'b1;
        regReq.addr   = addr;
        regReq.wrData = data;
        waitDriveSlot();
        regReq.wrEn   = 1'b0;
    endtask

    task automatic readReg(input regAddr addr, output logic [`REG_DATA_WIDTH-1:0] data);
        waitDriveSlot();
        regReq.rdEn = 1'b1;
        regReq.addr = addr;
        waitDriveSlot();
        regReq.rdEn = 1'b0;
        data = regReadData;                     // Registered on the edge just passed.
    endtask

    // Holds a constant level and sends one sample every other clock until count output strobes.
    task automatic driveLevel(input logic [`SAMPLE_WIDTH-1:0] level, input int count);
        int pulses;
        pulses   = 0;
        sampleIn = level;
        while (pulses < count) begin
            waitDriveSlot();
            if (gainOutEn) begin
                pulses++;
                if (!firstPulseSeen && samplesSent < `DECIM_RATE) begin
                    $display("ERROR: gainOutEn pulsed after only %0d samples", samplesSent);
                    errors++;
                end
                firstPulseSeen = 1'b1;
            end
            sampleEn = !sampleEn && (pulses < count);
            if (sampleEn) begin
                samplesSent++;
            end
        end
        sampleEn = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [`EXP_WIDTH-1:0]      expVal;
        logic [`EXP_WIDTH-1:0]      prevExp;
        logic [`MANT_WIDTH-1:0]     mantVal;
        logic [`SAMPLE_WIDTH-1:0]   level;
        logic [`OUT_WIDTH-1:0]      expected;
        logic [`REG_DATA_WIDTH-1:0] readData;
        int                         count;
        int                         base;
        int                         assertCount;
        string                      name;

        clk            = 1'b0;
        reset          = 1'b1;
        sampleEn       = 1'b0;
        sampleIn       = '0;
        regReq         = '0;
        checks         = 0;
        errors         = 0;
        samplesSent    = 0;
        firstPulseSeen = 1'b0;
        for (int i = 0; i < RecWords*MaxRecords; i++) begin
            stim[i] = '0;
        end
        $readmemh("sim/ddc_stimulus.txt", stim);
        numRecords   = 0;
        totalStrobes = 0;
        while (numRecords < MaxRecords && stim[numRecords*RecWords+3] != 0) begin
            totalStrobes += int'(stim[numRecords*RecWords+3]);
            numRecords++;
        end
        loaded = 1'b1;
        if (numRecords == 0) begin
            $display("ERROR: no records found in sim/ddc_stimulus.txt");
            errors++;
        end

        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        reset = 1'b0;
        waitDriveSlot();
        checkValue("reset gainOut", 32'(0), 32'(gainOut));
        checkValue("reset gainOutEn", 32'(0), 32'(gainOutEn));
        prevExp = '0;

        for (int r = 0; r < numRecords; r++) begin
            base     = r * RecWords;
            expVal   = stim[base][`EXP_WIDTH-1:0];
            mantVal  = stim[base+1][`MANT_WIDTH-1:0];
            level    = stim[base+2][`SAMPLE_WIDTH-1:0];
            count    = int'(stim[base+3]);
            expected = stim[base+4][`OUT_WIDTH-1:0];
            name     = $sformatf("record %0d", r);

            writeReg(REG_GAIN_EXP, `REG_DATA_WIDTH'(expVal));
            writeReg(REG_GAIN_MANT, mantVal);
            readReg(REG_GAIN_EXP, readData);
            checkValue({name, " exponent readback"}, 32'(expVal), 32'(readData));
            readReg(REG_GAIN_MANT, readData);
            checkValue({name, " mantissa readback"}, 32'(mantVal), 32'(readData));
            readReg(REG_STATUS, readData);      // No strobe yet so the old exponent is active.
            checkValue({name, " status before apply"}, 32'(prevExp), 32'(readData));

            driveLevel(level, count);
            checkValue({name, " gainOut"}, 32'(expected), 32'(gainOut));

            readReg(REG_STATUS, readData);
            checkValue({name, " status after apply"}, 32'(expVal), 32'(readData));
            prevExp = expVal;
        end

        assertCount = u_ddcChannel.u_ddcChannel_assertions.assertFails;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assertCount);
        if (errors == 0 && assertCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Each output strobe takes one decimated period of input samples.
    initial begin : watchdog
        longint limitNs;
        wait (loaded);
        limitNs = (longint'(totalStrobes) * `DECIM_RATE * SampleStep
                   + longint'(numRecords) * 40 + 1000) * ClkPeriod;
        #(limitNs);
        $display("ERROR: watchdog expired after %0d ns, the run did not complete", limitNs);
        $display("Something failed");
        $finish;
    end

endmodule

//--- sim/ddc_stimulus.txt
// One record per line, hex fields: exponent, mantissa, 24 bit input level,
// gainOutEn pulses to wait for, expected 18 bit gainOut.

// Unity gain, output is the level shifted down by 12.
0 0000 123456 06 00123
0 0000 EDCBAA 06 3FEDC
0 0000 7FFFFF 06 007FF
// Exponent shifts without saturation.
4 0000 001000 06 00010
9 0000 000ABC 06 00157
D 0000 FFFCDF 06 3F9BE
D 0000 00F000 06 1E000
F 0000 003FFF 06 1FFF8
// Shifter saturation, the last one at exponent 15.
C 0000 400000 06 1FFFF
C 0000 C00000 06 20001
F 0000 004000 06 1FFFF
// Mantissa scaling with truncation, then output saturation.
4 8000 001000 06 00018
0 8000 FFEFFF 06 3FFFD
0 8000 FFD000 06 3FFFB
9 4000 000ABC 06 001AC
6 FFFF 7FFFFF 06 1FFFF
6 FFFF 900000 06 20001
// Back to unity after a large gain.
0 0000 003000 07 00003
